//--- vlog.f
snes_rom_pkg.sv
snes_bus_if.sv
snes_bus_sampler.sv
mcu_rom_arbiter.sv
rom_bus_driver.sv
snes_rom_top.sv
snes_rom_props.sv
tb_snes_rom.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

top=tb_snes_rom
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module "$top" -f vlog.f -o "$top"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "All checks passed" "$log"; then
  exit 0
fi
echo "Pass message not found in $log"
exit 1

//--- tb_snes_rom.sv
`timescale 1ns/1ps
`default_nettype none

module tb_snes_rom;
  import snes_rom_pkg::*;

  localparam int dead_timeout = 200;
  localparam int wait_limit   = 2 * dead_timeout + 100;  // cycles allowed per wait

  logic        CLK2;
  logic        reset;
  logic [23:0] snes_addr_in;
  byte_t       snes_data_in;
  logic        snes_read_in;
  logic        snes_write_in;
  logic        snes_cpu_clk_in;
  byte_t       snes_data_out;
  logic        snes_databus_oe;
  logic        snes_databus_dir;
  logic [23:0] snes_mapped_addr;
  logic        rom_hit;
  logic        is_writable;
  logic        mcu_rrq;
  logic        mcu_wrq;
  logic [23:0] mcu_addr;
  byte_t       mcu_dout;
  byte_t       mcu_din;
  logic        mcu_rdy;
  logic [15:0] rom_data_in;
  logic [22:0] rom_addr;
  logic [15:0] rom_data_out;
  logic        rom_data_oe;
  logic        rom_we;
  logic        rom_bhe;
  logic        rom_ble;

  logic [15:0] rom_mem [4096];    // PSRAM model, low 12 word address bits
  logic [15:0] shadow  [4096];    // Contents the model should hold
  int          err_cnt     = 0;
  int          timeout_cnt = 0;
  logic [31:0] rng_state   = 32'd7;
  logic        cpu_run     = 1'b0;
  logic        cpu_level   = 1'b0;
  int          cpu_phase   = 0;
  logic        acc_read_q [$];
  logic [23:0] acc_addr_q [$];
  logic        rdy_seen    = 1'b1;
  logic        pop_read;
  logic [23:0] pop_addr;

  initial CLK2 = 1'b0;
  always #20 CLK2 = ~CLK2;

  snes_rom_top #(
    .DEAD_TIMEOUT  (dead_timeout),
    .ROM_CYCLE_LEN (7)
  ) dut0 (.*);

  //////////////////////////////////////////////////////////////////////
  // PSRAM model
  //////////////////////////////////////////////////////////////////////

  assign rom_data_in = rom_mem[rom_addr[11:0]];

  // Byte enables are active low
  always @(posedge CLK2) begin
    if (!reset && !rom_we) begin
      if (!rom_bhe) rom_mem[rom_addr[11:0]][15:8] <= rom_data_out[15:8];
      if (!rom_ble) rom_mem[rom_addr[11:0]][7:0] <= rom_data_out[7:0];
    end
  end

  // SNES CPU clock, free running or held at a level
  initial begin
    snes_cpu_clk_in = 1'b0;
    forever begin
      @(posedge CLK2);
      #2;
      if (cpu_run) begin
        if (cpu_phase == 5) begin
          cpu_phase = 0;
          snes_cpu_clk_in = ~snes_cpu_clk_in;
        end else begin
          cpu_phase++;
        end
      end else begin
        snes_cpu_clk_in = cpu_level;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reference and helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [15:0] fill_word(input int i);
    return 16'(i * 40503 + 4660);  // Odd multiplier keeps every word distinct
  endfunction

  function automatic byte_t expected_byte(input logic [23:0] a);
    logic [15:0] w;
    w = shadow[a[12:1]];
    return a[0] ? w[7:0] : w[15:8];  // Lane 1 is the low byte
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic draw(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  task automatic set_shadow_byte(input logic [23:0] a, input byte_t d);
    if (a[0]) shadow[a[12:1]][7:0] = d;
    else shadow[a[12:1]][15:8] = d;
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic next_cycle();
    @(posedge CLK2);
    #2;
  endtask

  task automatic wait_rdy_high();
    int n;
    n = 0;
    do begin
      @(negedge CLK2);
      n++;
    end while (!mcu_rdy && n < wait_limit);
    if (!mcu_rdy) begin
      $display("Timeout: mcu_rdy did not rise after the MCU request");
      timeout_cnt++;
    end
  endtask

  task automatic wait_buffer(input logic dir_level, input logic oe_level);
    int   n;
    logic hit;
    n = 0;
    do begin
      @(negedge CLK2);
      n++;
      hit = (snes_databus_dir === dir_level) && (snes_databus_oe === oe_level);
    end while (!hit && n < wait_limit);
    if (!hit) begin
      $display("Timeout: SNES buffer never reached dir=%0b oe=%0b", dir_level, oe_level);
      timeout_cnt++;
    end
  endtask

  // Direction alone marks the filtered read as active
  task automatic wait_read_dir();
    int n;
    n = 0;
    do begin
      @(negedge CLK2);
      n++;
    end while (snes_databus_dir !== 1'b1 && n < wait_limit);
    if (snes_databus_dir !== 1'b1) begin
      $display("Timeout: SNES buffer never turned toward the console");
      timeout_cnt++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus sequences
  //////////////////////////////////////////////////////////////////////

  task automatic mcu_access(input logic is_read, input logic [23:0] a, input byte_t d);
    next_cycle();
    mcu_addr = a;
    mcu_dout = d;
    mcu_rrq  = is_read;
    mcu_wrq  = ~is_read;
    acc_read_q.push_back(is_read);
    acc_addr_q.push_back(a);
    if (!is_read) set_shadow_byte(a, d);
    next_cycle();
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
    wait_rdy_high();
  endtask

  task automatic snes_read_check(input logic [23:0] a);
    next_cycle();
    snes_addr_in     = a;
    snes_mapped_addr = a;
    rom_hit          = 1'b1;
    snes_read_in     = 1'b0;           // Pins are active low
    wait_read_dir();
    check_val("rom_addr", 32'(rom_addr), 32'(a[23:1]));
    check_val("snes_data_out", 32'(snes_data_out), 32'(expected_byte(a)));
    check_val("snes_databus_oe", 32'(snes_databus_oe), 32'(1'b0));
    next_cycle();
    snes_read_in = 1'b1;
    wait_buffer(1'b0, 1'b1);
    next_cycle();
    rom_hit = 1'b0;
  endtask

  task automatic snes_write(input logic [23:0] a, input byte_t d, input logic writable);
    next_cycle();
    snes_addr_in     = a;
    snes_mapped_addr = a;
    snes_data_in     = d;
    rom_hit          = 1'b1;
    is_writable      = writable;
    cpu_level        = 1'b1;
    repeat (6) next_cycle();           // Data settles through the sampler
    snes_write_in = 1'b0;
    wait_buffer(1'b0, 1'b0);
    repeat (3) next_cycle();
    snes_write_in = 1'b1;
    wait_buffer(1'b0, 1'b1);
    next_cycle();
    cpu_level   = 1'b0;
    rom_hit     = 1'b0;
    is_writable = 1'b0;
    if (writable) set_shadow_byte(a, d);
  endtask

  // Compare on every rising mcu_rdy
  always @(negedge CLK2) begin
    if (!reset && mcu_rdy && !rdy_seen) begin
      if (acc_read_q.size() == 0) begin
        $display("mcu_rdy rose with no MCU access outstanding");
        err_cnt++;
      end else begin
        pop_read = acc_read_q.pop_front();
        pop_addr = acc_addr_q.pop_front();
        if (pop_read) check_val("mcu_din", 32'(mcu_din), 32'(expected_byte(pop_addr)));
      end
    end
    rdy_seen = mcu_rdy;
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    logic [23:0] a;
    logic [23:0] wr_addr;
    logic [23:0] keep_addr;
    reset            = 1'b1;
    snes_addr_in     = '0;
    snes_data_in     = '0;
    snes_read_in     = 1'b1;
    snes_write_in    = 1'b1;
    snes_mapped_addr = '0;
    rom_hit          = 1'b0;
    is_writable      = 1'b0;
    mcu_rrq          = 1'b0;
    mcu_wrq          = 1'b0;
    mcu_addr         = '0;
    mcu_dout         = '0;
    for (int i = 0; i < 4096; i++) begin
      rom_mem[i] <= fill_word(i);
      shadow[i] = fill_word(i);
    end
    repeat (3) next_cycle();
    reset = 1'b0;
    @(negedge CLK2);

    // State right after reset
    check_val("mcu_rdy", 32'(mcu_rdy), 32'(1'b1));
    check_val("rom_we", 32'(rom_we), 32'(1'b1));
    check_val("rom_data_oe", 32'(rom_data_oe), 32'(1'b0));
    check_val("snes_databus_dir", 32'(snes_databus_dir), 32'(1'b0));

    // Console dead, reads alternate lanes
    repeat (dead_timeout + 10) next_cycle();
    for (int i = 0; i < 6; i++) begin
      draw(r);
      mcu_access(1'b1, {11'h000, r[12:1], i[0]}, 8'h00);
    end

    for (int i = 0; i < 4; i++) begin
      draw(r);
      a = {11'h000, r[12:0]};
      mcu_access(1'b0, a, r[20:13]);
      check_val("rom_mem word", 32'(rom_mem[a[12:1]]), 32'(shadow[a[12:1]]));
      mcu_access(1'b1, a, 8'h00);
    end

    for (int i = 0; i < 4; i++) begin
      draw(r);
      snes_read_check({11'h000, r[12:0]});
    end

    // SNES writes, second one to a read-only area
    draw(r);
    wr_addr   = {11'h000, r[12:0]};
    keep_addr = wr_addr ^ 24'h000400;
    snes_write(wr_addr, r[20:13], 1'b1);
    check_val("rom_mem word", 32'(rom_mem[wr_addr[12:1]]), 32'(shadow[wr_addr[12:1]]));
    snes_write(keep_addr, ~r[20:13], 1'b0);
    check_val("rom_mem word", 32'(rom_mem[keep_addr[12:1]]), 32'(shadow[keep_addr[12:1]]));

    // Console alive with ROM traffic on every cycle
    next_cycle();
    rom_hit = 1'b1;
    cpu_run = 1'b1;
    mcu_access(1'b1, wr_addr, 8'h00);
    mcu_access(1'b1, keep_addr, 8'h00);
    for (int i = 0; i < 4; i++) begin
      draw(r);
      mcu_access(1'b1, {11'h000, r[12:0]}, 8'h00);
    end
    next_cycle();
    cpu_run = 1'b0;
    rom_hit = 1'b0;
    repeat (2) next_cycle();
    if (acc_read_q.size() != 0) begin
      $display("%0d MCU accesses never completed", acc_read_q.size());
      err_cnt++;
    end

    $display("Error count: %0d check errors, %0d timeouts", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- snes_rom_props.sv
`timescale 1ns/1ps
`default_nettype none

module snes_rom_props (
  input logic                     CLK2,
  input logic                     reset,
  input snes_rom_pkg::arb_state_e state,
  input logic                     mcu_rdy
);
  import snes_rom_pkg::*;

  // MCU side stays busy while the FSM owns an access
  busy_while_active: assert property (
    @(posedge CLK2) disable iff (reset) (state != st_idle) |-> !mcu_rdy
  ) else $error("mcu_rdy high while arbiter state is 0x%0h", state);

  state_onehot: assert property (@(posedge CLK2) disable iff (reset) $onehot(state))
    else $error("arbiter state 0x%0h is not one-hot", state);

  // Ready only comes back out of an end state
  rdy_from_end: assert property (
    @(posedge CLK2) disable iff (reset)
      $rose(mcu_rdy) |-> ($past(state) inside {st_mcu_rd_end, st_mcu_wr_end})
  ) else $error("mcu_rdy rose outside an end state");

endmodule

bind mcu_rom_arbiter snes_rom_props props0 (
  .CLK2    (CLK2),
  .reset   (reset),
  .state   (state),
  .mcu_rdy (mcu_rdy)
);

`default_nettype wire

//--- snes_rom_top.sv
`timescale 1ns/1ps
`default_nettype none

module snes_rom_top #(
  parameter int DEAD_TIMEOUT  = 86000,
  parameter int ROM_CYCLE_LEN = 7
) (
  input  logic                                 CLK2,
  input  logic                                 reset,
  // SNES bus
  input  logic [snes_rom_pkg::snes_addr_w-1:0] snes_addr_in,
  input  snes_rom_pkg::byte_t                  snes_data_in,
  input  logic                                 snes_read_in,
  input  logic                                 snes_write_in,
  input  logic                                 snes_cpu_clk_in,
  output snes_rom_pkg::byte_t                  snes_data_out,
  output logic                                 snes_databus_oe,
  output logic                                 snes_databus_dir,
  // Mapper results
  input  logic [snes_rom_pkg::snes_addr_w-1:0] snes_mapped_addr,
  input  logic                                 rom_hit,
  input  logic                                 is_writable,
  // MCU side
  input  logic                                 mcu_rrq,
  input  logic                                 mcu_wrq,
  input  logic [snes_rom_pkg::snes_addr_w-1:0] mcu_addr,
  input  snes_rom_pkg::byte_t                  mcu_dout,
  output snes_rom_pkg::byte_t                  mcu_din,
  output logic                                 mcu_rdy,
  // PSRAM
  input  logic [15:0]                          rom_data_in,
  output logic [snes_rom_pkg::rom_word_w-1:0]  rom_addr,
  output logic [15:0]                          rom_data_out,
  output logic                                 rom_data_oe,
  output logic                                 rom_we,
  output logic                                 rom_bhe,
  output logic                                 rom_ble
);
  import snes_rom_pkg::*;

  rom_byte_addr_u mcu_addr_u;
  rom_byte_addr_u mapped_addr_u;
  rom_byte_addr_u rom_req_addr;
  byte_t          rom_rd_byte;
  logic           mcu_hit;
  logic           mcu_wr_hit;

  snes_bus_if bus_if ();

  assign mcu_addr_u.flat    = mcu_addr;
  assign mapped_addr_u.flat = snes_mapped_addr;

  snes_bus_sampler u_sampler (
    .CLK2            (CLK2),
    .snes_addr_in    (snes_addr_in),
    .snes_data_in    (snes_data_in),
    .snes_read_in    (snes_read_in),
    .snes_write_in   (snes_write_in),
    .snes_cpu_clk_in (snes_cpu_clk_in),
    .bus             (bus_if.sampler)
  );

  mcu_rom_arbiter #(
    .DEAD_TIMEOUT  (DEAD_TIMEOUT),
    .ROM_CYCLE_LEN (ROM_CYCLE_LEN)
  ) u_arbiter (
    .CLK2         (CLK2),
    .reset        (reset),
    .bus          (bus_if.arbiter),
    .rom_hit      (rom_hit),
    .mcu_rrq      (mcu_rrq),
    .mcu_wrq      (mcu_wrq),
    .mcu_addr     (mcu_addr_u),
    .rom_rd_byte  (rom_rd_byte),
    .mcu_din      (mcu_din),
    .mcu_rdy      (mcu_rdy),
    .mcu_hit      (mcu_hit),
    .mcu_wr_hit   (mcu_wr_hit),
    .rom_req_addr (rom_req_addr)
  );

  rom_bus_driver u_driver (
    .bus              (bus_if.driver),
    .snes_mapped_addr (mapped_addr_u),
    .rom_hit          (rom_hit),
    .is_writable      (is_writable),
    .mcu_hit          (mcu_hit),
    .mcu_wr_hit       (mcu_wr_hit),
    .rom_req_addr     (rom_req_addr),
    .mcu_dout         (mcu_dout),
    .rom_data_in      (rom_data_in),
    .rom_addr         (rom_addr),
    .rom_data_out     (rom_data_out),
    .rom_data_oe      (rom_data_oe),
    .rom_we           (rom_we),
    .rom_bhe          (rom_bhe),
    .rom_ble          (rom_ble),
    .rom_rd_byte      (rom_rd_byte),
    .snes_data_out    (snes_data_out),
    .snes_databus_oe  (snes_databus_oe),
    .snes_databus_dir (snes_databus_dir)
  );

endmodule

`default_nettype wire

//--- rom_bus_driver.sv
`timescale 1ns/1ps
`default_nettype none

module rom_bus_driver (
  snes_bus_if.driver                          bus,
  input  snes_rom_pkg::rom_byte_addr_u        snes_mapped_addr,
  input  logic                                rom_hit,
  input  logic                                is_writable,
  input  logic                                mcu_hit,
  input  logic                                mcu_wr_hit,
  input  snes_rom_pkg::rom_byte_addr_u        rom_req_addr,
  input  snes_rom_pkg::byte_t                 mcu_dout,
  input  logic [15:0]                         rom_data_in,
  output logic [snes_rom_pkg::rom_word_w-1:0] rom_addr,
  output logic [15:0]                         rom_data_out,
  output logic                                rom_data_oe,
  output logic                                rom_we,
  output logic                                rom_bhe,
  output logic                                rom_ble,
  output snes_rom_pkg::byte_t                 rom_rd_byte,
  output snes_rom_pkg::byte_t                 snes_data_out,
  output logic                                snes_databus_oe,
  output logic                                snes_databus_dir
);
  import snes_rom_pkg::*;

  rom_byte_addr_u acc_addr;
  logic           lane;
  byte_t          wr_byte;
  logic           snes_wr;

  // MCU owns the PSRAM while its access runs
  assign acc_addr = mcu_hit ? rom_req_addr : snes_mapped_addr;
  assign rom_addr = acc_addr.split.word;
  assign lane     = acc_addr.split.lane;

  //////////////////////////////////////////////////////////////////////
  // Write path
  //////////////////////////////////////////////////////////////////////

  assign snes_wr = rom_hit & is_writable & bus.cpu_clk & bus.wr_active & ~mcu_hit;
  assign wr_byte = mcu_wr_hit ? mcu_dout : bus.snes_data;

  assign rom_we       = ~(mcu_wr_hit | snes_wr);     // active low
  assign rom_data_oe  = ~rom_we;
  assign rom_data_out = lane ? {8'h00, wr_byte} : {wr_byte, 8'h00};

  // Byte enables are active low
  assign rom_bhe = lane;
  assign rom_ble = ~lane;

  //////////////////////////////////////////////////////////////////////
  // Read path and SNES buffer
  //////////////////////////////////////////////////////////////////////

  assign rom_rd_byte   = lane ? rom_data_in[7:0] : rom_data_in[15:8];
  assign snes_data_out = rom_rd_byte;

  assign snes_databus_oe  = ~(rom_hit & (bus.rd_active | bus.wr_active));
  assign snes_databus_dir = bus.rd_active;        // 1 drives toward the console

endmodule

`default_nettype wire

//--- mcu_rom_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mcu_rom_arbiter #(
  parameter int DEAD_TIMEOUT  = 86000,
  parameter int ROM_CYCLE_LEN = 7
) (
  input  logic                         CLK2,
  input  logic                         reset,
  snes_bus_if.arbiter                  bus,
  input  logic                         rom_hit,
  input  logic                         mcu_rrq,
  input  logic                         mcu_wrq,
  input  snes_rom_pkg::rom_byte_addr_u mcu_addr,
  input  snes_rom_pkg::byte_t          rom_rd_byte,
  output snes_rom_pkg::byte_t          mcu_din,
  output logic                         mcu_rdy,
  output logic                         mcu_hit,
  output logic                         mcu_wr_hit,
  output snes_rom_pkg::rom_byte_addr_u rom_req_addr
);
  import snes_rom_pkg::*;

  localparam int dead_cnt_w = $clog2(DEAD_TIMEOUT + 2);
  localparam int delay_w    = (ROM_CYCLE_LEN < 2) ? 1 : $clog2(ROM_CYCLE_LEN + 1);

  arb_state_e            state;
  logic [delay_w-1:0]    mem_delay;
  logic [dead_cnt_w-1:0] dead_cnt;
  logic                  snes_dead;
  logic                  rd_pend;
  logic                  wr_pend;
  logic                  free_strobe;
  logic                  free_slot;
  logic                  rd_req;
  logic                  wr_req;

  //////////////////////////////////////////////////////////////////////
  // Liveness monitor
  //////////////////////////////////////////////////////////////////////

  // Bus strobes also restart the count during a stretched low phase
  always_ff @(posedge CLK2) begin
    if (reset || bus.cpu_clk || bus.rd_start || bus.rd_end || bus.wr_end) begin
      dead_cnt <= '0;
    end else if (dead_cnt <= dead_cnt_w'(DEAD_TIMEOUT)) begin
      dead_cnt <= dead_cnt + 1'b1;                     // saturates past timeout
    end
  end

  always_ff @(posedge CLK2) begin
    if (reset) begin
      snes_dead <= 1'b1;
    end else if (bus.cpu_clk) begin
      snes_dead <= 1'b0;
    end else if (dead_cnt > dead_cnt_w'(DEAD_TIMEOUT)) begin
      snes_dead <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Requests and free slots
  //////////////////////////////////////////////////////////////////////

  assign rd_req = mcu_rrq & mcu_rdy;
  assign wr_req = mcu_wrq & mcu_rdy & ~mcu_rrq;

  // Cycle without ROM access leaves the bus idle after cycle start
  always_ff @(posedge CLK2) begin
    if (reset) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= bus.cycle_start & ~rom_hit;
    end
  end

  assign free_slot = bus.cycle_end | free_strobe;

  always_ff @(posedge CLK2) begin
    if (reset) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (rd_req || wr_req) begin
      rd_pend <= rd_req;
      wr_pend <= wr_req;
      mcu_rdy <= 1'b0;
    end else if (state == st_mcu_rd_end || state == st_mcu_wr_end) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (rd_req || wr_req) begin
      rom_req_addr <= mcu_addr;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Access FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset) begin
      state <= st_idle;
    end else if (snes_dead && bus.cpu_clk) begin
      state <= st_idle;  // console woke up, pending request restarts later
    end else begin
      unique case (state)
        st_idle: begin
          if (free_slot || snes_dead) begin
            if (rd_pend) begin
              state <= st_mcu_rd_addr;
            end else if (wr_pend) begin
              state <= st_mcu_wr_addr;
            end
          end
        end
        st_mcu_rd_addr: if (mem_delay == '0) state <= st_mcu_rd_end;
        st_mcu_wr_addr: if (mem_delay == '0) state <= st_mcu_wr_end;
        default:        state <= st_idle;                // end states
      endcase
    end
  end

  always_ff @(posedge CLK2) begin
    if (state == st_idle) begin
      mem_delay <= delay_w'(ROM_CYCLE_LEN);
    end else if (mcu_hit) begin
      mem_delay <= mem_delay - 1'b1;
    end
  end

  // Last sample before the end state holds the settled byte
  always_ff @(posedge CLK2) begin
    if (state == st_mcu_rd_addr) begin
      mcu_din <= rom_rd_byte;
    end
  end

  assign mcu_wr_hit = (state == st_mcu_wr_addr);
  assign mcu_hit    = (state == st_mcu_rd_addr) | mcu_wr_hit;

endmodule

`default_nettype wire

//--- snes_bus_sampler.sv
`timescale 1ns/1ps
`default_nettype none

module snes_bus_sampler (
  input  logic                                 CLK2,
  input  logic [snes_rom_pkg::snes_addr_w-1:0] snes_addr_in,
  input  snes_rom_pkg::byte_t                  snes_data_in,
  input  logic                                 snes_read_in,
  input  logic                                 snes_write_in,
  input  logic                                 snes_cpu_clk_in,
  snes_bus_if.sampler                          bus
);
  import snes_rom_pkg::*;

  localparam int addr_stages = 6;
  localparam int data_stages = 4;

  logic [7:0] read_sr;
  logic [7:0] write_sr;
  logic [5:0] cpu_clk_sr;     // cycle strobes look at a shorter window

  logic [snes_addr_w-1:0] addr_pipe [addr_stages];
  byte_t                  data_pipe [data_stages];

  logic [5:0] read_hist;
  logic [5:0] write_hist;
  logic [3:0] clk_hist;

  //////////////////////////////////////////////////////////////////////
  // Synchronizers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    read_sr    <= {read_sr[6:0], snes_read_in};
    write_sr   <= {write_sr[6:0], snes_write_in};
    cpu_clk_sr <= {cpu_clk_sr[4:0], snes_cpu_clk_in};
  end

  always_ff @(posedge CLK2) begin
    addr_pipe[0] <= snes_addr_in;
    data_pipe[0] <= snes_data_in;
    for (int i = 1; i < addr_stages; i++) begin
      addr_pipe[i] <= addr_pipe[i-1];
    end
    for (int i = 1; i < data_stages; i++) begin
      data_pipe[i] <= data_pipe[i-1];
    end
  end

  // Bitwise AND of two late samples rejects single-cycle glitches
  assign bus.snes_addr = addr_pipe[addr_stages-1] & addr_pipe[addr_stages-2];
  assign bus.snes_data = data_pipe[data_stages-1] & data_pipe[data_stages-2];

  //////////////////////////////////////////////////////////////////////
  // Levels and edge strobes
  //////////////////////////////////////////////////////////////////////

  // Pins are active low
  assign bus.rd_active = ~(read_sr[2] & read_sr[1]);
  assign bus.wr_active = ~(write_sr[2] & write_sr[1]);
  assign bus.cpu_clk   = cpu_clk_sr[2] & cpu_clk_sr[1];

  // Adjacent-sample history, newest bit at the right
  assign read_hist  = read_sr[6:1] & read_sr[7:2];
  assign write_hist = write_sr[6:1] & write_sr[7:2];
  assign clk_hist   = cpu_clk_sr[4:1] & cpu_clk_sr[5:2];

  assign bus.rd_start    = (read_hist == 6'b111110);   // /RD falling
  assign bus.rd_end      = (read_hist == 6'b000001);   // /RD rising
  assign bus.wr_end      = (write_hist == 6'b000001);
  assign bus.cycle_start = (clk_hist == 4'b0001);
  assign bus.cycle_end   = (clk_hist == 4'b1110);

endmodule

`default_nettype wire

//--- snes_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// Filtered SNES bus as seen in the CLK2 domain
interface snes_bus_if;
  import snes_rom_pkg::*;

  logic [snes_addr_w-1:0] snes_addr;
  byte_t                  snes_data;

  // Levels
  logic rd_active;
  logic wr_active;
  logic cpu_clk;

  // One-cycle strobes
  logic rd_start;
  logic rd_end;
  logic wr_end;
  logic cycle_start;
  logic cycle_end;

  modport sampler (
    output snes_addr, snes_data, rd_active, wr_active, cpu_clk,
    output rd_start, rd_end, wr_end, cycle_start, cycle_end
  );

  modport arbiter (input cpu_clk, rd_start, rd_end, wr_end, cycle_start, cycle_end);

  modport driver (input snes_data, rd_active, wr_active, cpu_clk);

endinterface

`default_nettype wire

//--- snes_rom_pkg.sv
`default_nettype none

package snes_rom_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  localparam int snes_addr_w = 24;  // SNES and MCU byte address
  localparam int rom_word_w  = 23;  // PSRAM word address

  typedef logic [7:0] byte_t;

  //////////////////////////////////////////////////////////////////////
  // ROM byte address, flat or split into word and lane
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [rom_word_w-1:0] word;
    logic                  lane;  // 1 selects the low byte
  } rom_word_lane_t;

  typedef union packed {
    logic [snes_addr_w-1:0] flat;
    rom_word_lane_t         split;
  } rom_byte_addr_u;

  //////////////////////////////////////////////////////////////////////
  // MCU access FSM, one-hot
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [4:0] {
    st_idle        = 5'b00001,
    st_mcu_rd_addr = 5'b00010,
    st_mcu_rd_end  = 5'b00100,
    st_mcu_wr_addr = 5'b01000,
    st_mcu_wr_end  = 5'b10000
  } arb_state_e;

endpackage

`default_nettype wire
